// File: Bender.yml
package:
  name: xgmii_tx_mac

sources:
  - files:
      - design/xgmii_tx_pkg.sv
      - design/crc32_slice.sv
      - design/tx_term_builder.sv
      - design/tx_frame_ctrl.sv
      - design/xgmii_tx_mac.sv
  - target: simulation
    include_dirs:
      - verification
    files:
      - verification/tb_xgmii_tx_mac.sv

// File: design/crc32_slice.sv
// Ethernet CRC-32 over one column per cycle with per-lane enables, used for the transmit FCS
`timescale 1ns/100ps
`default_nettype none

module crc32_slice import xgmii_tx_pkg::*; (
    input  wire        i_clk,
    input  wire        i_clear,
    input  wire lane_data_t i_data,
    input  wire lane_ctl_t  i_byte_en,
    output logic [31:0] o_crc
);

    logic [31:0] crc_q;
    logic [31:0] crc_next;

    // One byte through the reflected polynomial, LSB first
    function automatic logic [31:0] crc_byte(input logic [31:0] crc_in, input logic [7:0] data);
        logic [31:0] c;
        c = crc_in;
        for (int b = 0; b < 8; b++) begin
            c = (c >> 1) ^ (CRC_POLY_REFLECTED & {32{c[0] ^ data[b]}});
        end
        return c;
    endfunction

    // Lanes in order, lane 0 being the earliest byte
    always_comb begin
        crc_next = crc_q;
        for (int l = 0; l < DATA_NBYTES; l++) begin
            if (i_byte_en[l]) begin
                crc_next = crc_byte(crc_next, i_data[8*l +: 8]);
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_clear) begin
            crc_q <= '1;
        end else begin
            crc_q <= crc_next;
        end
    end

    assign o_crc = ~crc_q;

    // Gaps between enabled lanes would reorder bytes in the FCS
    a_contiguous_en: assert property (@(posedge i_clk)
        (i_byte_en != '0) |-> (i_byte_en inside {4'b0001, 4'b0011, 4'b0111, 4'b1111}));

endmodule

`default_nettype wire

// File: design/tx_frame_ctrl.sv
// Frame sequencer of the transmit MAC, owns the input handshake and picks every XGMII column
`timescale 1ns/100ps
`default_nettype none

module tx_frame_ctrl import xgmii_tx_pkg::*; #(
    parameter int MIN_FRAME_BYTES = 60,
    parameter int IPG_BYTES = 12
) (
    input  wire        i_clk,
    input  wire        i_reset,

    input  wire lane_data_t i_tdata,
    input  wire lane_ctl_t  i_tkeep,
    input  wire        i_tlast,
    input  wire        i_tvalid,
    output logic       o_tready,

    input  wire lane_data_t i_term_first_data,
    input  wire lane_ctl_t  i_term_first_ctl,
    input  wire lane_data_t i_term_held_data,
    input  wire lane_ctl_t  i_term_held_ctl,
    input  wire [TERM_IDLE_W-1:0] i_term_idle_bytes,

    output lane_data_t o_beat_data,
    output lane_ctl_t  o_beat_keep,
    output logic       o_term_capture,
    output logic [1:0] o_term_index,

    output logic       o_crc_clear,
    output lane_data_t o_crc_data,
    output lane_ctl_t  o_crc_byte_en,

    output lane_data_t o_xgmii_data,
    output lane_ctl_t  o_xgmii_ctl
);

    // Counter widths leave room for one column of overshoot
    localparam int CNT_W = $clog2(MIN_FRAME_BYTES + 2 * DATA_NBYTES);
    localparam int IPG_W = $clog2(IPG_BYTES + 4 * TERM_COLS);

    localparam lane_data_t IDLE_COL = {DATA_NBYTES{RS_IDLE}};
    localparam lane_data_t START_COL = {MAC_PRE, MAC_PRE, MAC_PRE, RS_START};
    localparam lane_data_t SFD_COL = {MAC_SFD, MAC_PRE, MAC_PRE, MAC_PRE};

    tx_state_t state, next_state;
    term_sel_t col_sel;
    lane_data_t const_data;
    lane_ctl_t const_ctl;

    // Two-stage delay line, stage 0 feeds the CRC and stage 1 feeds the output
    logic d0_valid, d0_last;
    lane_data_t d0_data;
    lane_ctl_t d0_keep;
    logic d1_last, d1_pad;
    lane_data_t d1_data;
    lane_ctl_t d1_keep;
    lane_data_t data_mask;

    logic beat_accept;
    logic seen_last;
    logic need_pad;
    logic frame_padded;
    logic pad_feed;
    logic pad_fed_q;
    logic [CNT_W-1:0] fed_cnt, fed_sum;
    logic [IPG_W-1:0] ipg_cnt;
    logic [1:0] term_cnt;

    assign o_tready = (state == IDLE || state == PREAMBLE || state == DATA) && !seen_last;
    assign beat_accept = i_tvalid && o_tready;

    // Unused lanes of the last beat become zero pad bytes
    always_comb begin
        for (int l = 0; l < DATA_NBYTES; l++) begin
            data_mask[8*l +: 8] = {8{i_tkeep[l]}};
        end
    end

    // A short frame widens its last beat to a full column and pads behind it
    assign need_pad = d0_last &&
        (32'(fed_cnt) + 32'(keep_to_bytes(d0_keep)) < MIN_FRAME_BYTES);
    assign pad_feed = frame_padded && !d0_valid && (fed_cnt < CNT_W'(MIN_FRAME_BYTES));
    assign fed_sum = fed_cnt + CNT_W'(DATA_NBYTES);

    assign o_crc_clear = (state == IDLE);
    assign o_crc_data = pad_feed ? '0 : d0_data;
    assign o_crc_byte_en = pad_feed ? '1 :
                           !d0_valid ? '0 :
                           need_pad ? '1 : d0_keep;

    // A padded end leaves no data bytes for the terminate columns
    assign o_beat_data = d1_data;
    assign o_beat_keep = (state == PADDING) ? '0 : d1_keep;
    assign o_term_capture = (next_state == TERM) && (state != TERM);
    assign o_term_index = term_cnt;

    always_comb begin
        next_state = state;
        col_sel = CONSTANT;
        const_data = IDLE_COL;
        const_ctl = '1;
        case (state)
            IDLE: begin
                if (i_tvalid) begin
                    next_state = PREAMBLE;
                    const_data = START_COL;
                    const_ctl = 4'b0001;
                end
            end
            PREAMBLE: begin
                next_state = DATA;
                const_data = SFD_COL;
                const_ctl = '0;
            end
            DATA: begin
                col_sel = DELAYED_DATA;
                if (d1_last && d1_pad) begin
                    next_state = PADDING;
                end else if (d1_last) begin
                    next_state = TERM;
                    col_sel = TERM_FIRST;
                end
            end
            PADDING: begin
                if (pad_fed_q) begin
                    const_data = '0;
                    const_ctl = '0;
                end else begin
                    next_state = TERM;
                    col_sel = TERM_FIRST;
                end
            end
            TERM: begin
                col_sel = TERM_HELD;
                if (term_cnt == 2'(TERM_COLS - 2)) begin
                    next_state = (ipg_cnt >= IPG_W'(IPG_BYTES)) ? IDLE : IPG;
                end
            end
            IPG: begin
                if (ipg_cnt + IPG_W'(DATA_NBYTES) >= IPG_W'(IPG_BYTES)) begin
                    next_state = IDLE;
                end
            end
            default: begin
                next_state = IDLE;
            end
        endcase
    end

    always_comb begin
        case (col_sel)
            DELAYED_DATA: begin
                o_xgmii_data = d1_data;
                o_xgmii_ctl = '0;
            end
            TERM_FIRST: begin
                o_xgmii_data = i_term_first_data;
                o_xgmii_ctl = i_term_first_ctl;
            end
            TERM_HELD: begin
                o_xgmii_data = i_term_held_data;
                o_xgmii_ctl = i_term_held_ctl;
            end
            default: begin
                o_xgmii_data = const_data;
                o_xgmii_ctl = const_ctl;
            end
        endcase
    end

    // Reset enters IPG so the link idles before the first frame
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state <= IPG;
            d0_valid <= 1'b0;
            d0_last <= 1'b0;
            d1_last <= 1'b0;
            d1_pad <= 1'b0;
            seen_last <= 1'b0;
            fed_cnt <= '0;
            frame_padded <= 1'b0;
            pad_fed_q <= 1'b0;
            ipg_cnt <= '0;
            term_cnt <= '0;
        end else begin
            state <= next_state;
            d0_valid <= beat_accept;
            d0_last <= beat_accept && i_tlast;
            d1_last <= d0_last;
            d1_pad <= need_pad;
            pad_fed_q <= pad_feed;

            if (beat_accept && i_tlast) begin
                seen_last <= 1'b1;
            end else if (o_term_capture) begin
                seen_last <= 1'b0;
            end

            // Bytes fed to the CRC, saturating at the minimum frame size
            if (state == IDLE) begin
                fed_cnt <= '0;
            end else if (d0_valid || pad_feed) begin
                fed_cnt <= (fed_sum >= CNT_W'(MIN_FRAME_BYTES)) ?
                           CNT_W'(MIN_FRAME_BYTES) : fed_sum;
            end

            if (state == IDLE) begin
                frame_padded <= 1'b0;
            end else if (need_pad) begin
                frame_padded <= 1'b1;
            end

            // Idle bytes already in the terminate columns start the gap count
            if (o_term_capture) begin
                ipg_cnt <= IPG_W'(i_term_idle_bytes);
            end else if (state == IPG) begin
                ipg_cnt <= ipg_cnt + IPG_W'(DATA_NBYTES);
            end

            if (o_term_capture) begin
                term_cnt <= '0;
            end else if (state == TERM) begin
                term_cnt <= term_cnt + 2'd1;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        d0_data <= i_tdata & data_mask;
        d0_keep <= i_tkeep;
        d1_data <= d0_data;
        d1_keep <= need_pad ? '1 : d0_keep;
    end

    // Input must not drop valid inside a frame
    a_valid_held: assert property (@(posedge i_clk) disable iff (i_reset)
        (i_tvalid && !(o_tready && i_tlast)) |=> i_tvalid);

    a_full_keep: assert property (@(posedge i_clk) disable iff (i_reset)
        (beat_accept && !i_tlast) |-> (i_tkeep == '1));

endmodule

`default_nettype wire

// File: design/tx_term_builder.sv
// Builds the four terminate columns of a frame end for the transmit MAC frame controller
`timescale 1ns/100ps
`default_nettype none

module tx_term_builder import xgmii_tx_pkg::*; (
    input  wire        i_clk,
    input  wire        i_reset,

    input  wire lane_data_t i_beat_data,
    input  wire lane_ctl_t  i_beat_keep,
    input  wire [31:0] i_crc,
    input  wire        i_capture,
    input  wire [1:0]  i_term_index,

    output lane_data_t o_term_first_data,
    output lane_ctl_t  o_term_first_ctl,
    output lane_data_t o_term_held_data,
    output lane_ctl_t  o_term_held_ctl,
    output logic [TERM_IDLE_W-1:0] o_term_idle_bytes
);

    localparam int TERM_BYTES = TERM_COLS * DATA_NBYTES;

    logic [2:0] n_data;
    logic [TERM_BYTES-1:0][7:0] term_bytes;
    logic [TERM_BYTES-1:0] term_ctl;

    lane_data_t held_data [TERM_COLS-1];
    lane_ctl_t held_ctl [TERM_COLS-1];

    assign n_data = keep_to_bytes(i_beat_keep);

    // Remaining data, then CRC lowest byte first, then T, then idle fill
    always_comb begin
        for (int i = 0; i < TERM_BYTES; i++) begin
            if (i < int'(n_data)) begin
                term_bytes[i] = i_beat_data[8*(i % DATA_NBYTES) +: 8];
                term_ctl[i] = 1'b0;
            end else if (i < int'(n_data) + 4) begin
                term_bytes[i] = i_crc[8*((i - int'(n_data)) % 4) +: 8];
                term_ctl[i] = 1'b0;
            end else if (i == int'(n_data) + 4) begin
                term_bytes[i] = RS_TERM;
                term_ctl[i] = 1'b1;
            end else begin
                term_bytes[i] = RS_IDLE;
                term_ctl[i] = 1'b1;
            end
        end
    end

    assign o_term_first_data = term_bytes[DATA_NBYTES-1:0];
    assign o_term_first_ctl = term_ctl[DATA_NBYTES-1:0];

    // Everything after the terminate byte is idle
    assign o_term_idle_bytes = TERM_IDLE_W'(TERM_BYTES - 5 - int'(n_data));

    always_ff @(posedge i_clk) begin
        for (int c = 1; c < TERM_COLS; c++) begin
            if (i_capture) begin
                held_data[c-1] <= term_bytes[DATA_NBYTES*c +: DATA_NBYTES];
            end
        end
    end

    always_ff @(posedge i_clk) begin
        for (int c = 1; c < TERM_COLS; c++) begin
            if (i_reset) begin
                held_ctl[c-1] <= '1;
            end else if (i_capture) begin
                held_ctl[c-1] <= term_ctl[DATA_NBYTES*c +: DATA_NBYTES];
            end
        end
    end

    always_comb begin
        case (i_term_index)
            2'd0: begin
                o_term_held_data = held_data[0];
                o_term_held_ctl = held_ctl[0];
            end
            2'd1: begin
                o_term_held_data = held_data[1];
                o_term_held_ctl = held_ctl[1];
            end
            default: begin
                o_term_held_data = held_data[2];
                o_term_held_ctl = held_ctl[2];
            end
        endcase
    end

    // Frame controller hands over a legal end pattern, zero keep for a padded end
    a_legal_keep: assert property (@(posedge i_clk) disable iff (i_reset)
        i_capture |-> (i_beat_keep inside {4'b0000, 4'b0001, 4'b0011, 4'b0111, 4'b1111}));

endmodule

`default_nettype wire

// File: design/xgmii_tx_mac.sv
// Transmit MAC top level, byte stream in and XGMII out, instantiated by the system or testbench
`timescale 1ns/100ps
`default_nettype none

module xgmii_tx_mac import xgmii_tx_pkg::*; #(
    parameter int MIN_FRAME_BYTES = 60,
    parameter int IPG_BYTES = 12
) (
    input  wire        i_clk,
    input  wire        i_reset,

    // Byte stream input
    input  wire lane_data_t i_tdata,
    input  wire lane_ctl_t  i_tkeep,
    input  wire        i_tlast,
    input  wire        i_tvalid,
    output logic       o_tready,

    // XGMII transmit
    output lane_data_t o_xgmii_data,
    output lane_ctl_t  o_xgmii_ctl
);

    lane_data_t beat_data;
    lane_ctl_t beat_keep;
    logic term_capture;
    logic [1:0] term_index;

    logic crc_clear;
    lane_data_t crc_data;
    lane_ctl_t crc_byte_en;
    logic [31:0] crc;

    lane_data_t term_first_data;
    lane_ctl_t term_first_ctl;
    lane_data_t term_held_data;
    lane_ctl_t term_held_ctl;
    logic [TERM_IDLE_W-1:0] term_idle_bytes;

    tx_frame_ctrl #(
        .MIN_FRAME_BYTES(MIN_FRAME_BYTES),
        .IPG_BYTES(IPG_BYTES)
    ) u_frame_ctrl (
        .i_clk(i_clk),
        .i_reset(i_reset),
        .i_tdata(i_tdata),
        .i_tkeep(i_tkeep),
        .i_tlast(i_tlast),
        .i_tvalid(i_tvalid),
        .o_tready(o_tready),
        .i_term_first_data(term_first_data),
        .i_term_first_ctl(term_first_ctl),
        .i_term_held_data(term_held_data),
        .i_term_held_ctl(term_held_ctl),
        .i_term_idle_bytes(term_idle_bytes),
        .o_beat_data(beat_data),
        .o_beat_keep(beat_keep),
        .o_term_capture(term_capture),
        .o_term_index(term_index),
        .o_crc_clear(crc_clear),
        .o_crc_data(crc_data),
        .o_crc_byte_en(crc_byte_en),
        .o_xgmii_data(o_xgmii_data),
        .o_xgmii_ctl(o_xgmii_ctl)
    );

    tx_term_builder u_term_builder (
        .i_clk(i_clk),
        .i_reset(i_reset),
        .i_beat_data(beat_data),
        .i_beat_keep(beat_keep),
        .i_crc(crc),
        .i_capture(term_capture),
        .i_term_index(term_index),
        .o_term_first_data(term_first_data),
        .o_term_first_ctl(term_first_ctl),
        .o_term_held_data(term_held_data),
        .o_term_held_ctl(term_held_ctl),
        .o_term_idle_bytes(term_idle_bytes)
    );

    crc32_slice u_crc (
        .i_clk(i_clk),
        .i_clear(crc_clear),
        .i_data(crc_data),
        .i_byte_en(crc_byte_en),
        .o_crc(crc)
    );

endmodule

`default_nettype wire

// File: design/xgmii_tx_pkg.sv
// Shared XGMII codes, lane types and frame state encodings, imported by every transmit MAC module
`default_nettype none

package xgmii_tx_pkg;

    // Column geometry
    localparam int DATA_WIDTH = 32;
    localparam int DATA_NBYTES = DATA_WIDTH / 8;

    typedef logic [DATA_WIDTH-1:0] lane_data_t;
    typedef logic [DATA_NBYTES-1:0] lane_ctl_t;

    // Reconciliation sublayer control characters
    localparam logic [7:0] RS_IDLE = 8'h07;
    localparam logic [7:0] RS_START = 8'hFB;
    localparam logic [7:0] RS_TERM = 8'hFD;
    localparam logic [7:0] RS_ERROR = 8'hFE;

    // Preamble and start-of-frame delimiter bytes
    localparam logic [7:0] MAC_PRE = 8'h55;
    localparam logic [7:0] MAC_SFD = 8'hD5;

    localparam logic [31:0] CRC_POLY_REFLECTED = 32'hEDB88320;

    // Terminate sequence is four columns, the first sent as soon as it is built
    localparam int TERM_COLS = 4;
    // Wide enough for the idle bytes inside the terminate sequence
    localparam int TERM_IDLE_W = 4;

    typedef enum logic [2:0] {
        IDLE,
        PREAMBLE,
        DATA,
        PADDING,
        TERM,
        IPG
    } tx_state_t;

    // Source of the outgoing column
    typedef enum logic [1:0] {
        DELAYED_DATA,
        TERM_FIRST,
        TERM_HELD,
        CONSTANT
    } term_sel_t;

    // Byte count of a keep vector, which is contiguous from lane 0
    function automatic logic [2:0] keep_to_bytes(input lane_ctl_t keep);
        logic [2:0] count;
        count = '0;
        for (int i = 0; i < DATA_NBYTES; i++) begin
            count = count + 3'(keep[i]);
        end
        return count;
    endfunction

endpackage

`default_nettype wire

// File: verification/tb_frame_model.svh
// Reference frame model for the XGMII transmit MAC testbench, included inside the testbench module
`ifndef TB_FRAME_MODEL_SVH
`define TB_FRAME_MODEL_SVH

// Bitwise Ethernet CRC-32 over n bytes of a row, zero bytes past the payload
function automatic logic [31:0] ref_crc(input int row, input int n);
    logic [31:0] c;
    logic [7:0] b;
    c = 32'hFFFF_FFFF;
    for (int i = 0; i < n; i++) begin
        b = (i < frame_len[row]) ? payload[row][i] : 8'h00;
        for (int k = 0; k < 8; k++) begin
            if (c[0] ^ b[k]) begin
                c = (c >> 1) ^ CRC_POLY_REFLECTED;
            end else begin
                c = c >> 1;
            end
        end
    end
    return ~c;
endfunction

task automatic push_expected(input logic [7:0] b, input logic c);
    exp_byte.push_back(b);
    exp_ctl.push_back(c);
endtask

// Byte stream of one frame from the start byte through the terminate byte
task automatic build_expected(input int row);
    int n;
    logic [31:0] fcs;
    n = (frame_len[row] < MIN_BYTES) ? MIN_BYTES : frame_len[row];
    fcs = ref_crc(row, n);
    exp_byte.delete();
    exp_ctl.delete();
    // Start column pair, S in lane 0 and SFD in lane 3 of the second column
    push_expected(RS_START, 1'b1);
    repeat (6) begin
        push_expected(MAC_PRE, 1'b0);
    end
    push_expected(MAC_SFD, 1'b0);
    for (int i = 0; i < n; i++) begin
        push_expected((i < frame_len[row]) ? payload[row][i] : 8'h00, 1'b0);
    end
    // FCS goes out lowest byte first
    for (int k = 0; k < 4; k++) begin
        push_expected(fcs[8*k +: 8], 1'b0);
    end
    push_expected(RS_TERM, 1'b1);
endtask

task automatic check_value(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
    checks++;
    if (expected !== actual) begin
        errors++;
        $display("CHECK FAILED at %0t: %s expected 0x%0h, got 0x%0h",
                 $time, name, expected, actual);
    end
endtask

`endif

// File: verification/tb_xgmii_tx_mac.sv
// Testbench for the XGMII transmit MAC, sends a table of frames and checks every output column
`timescale 1ns/100ps
`default_nettype none

module tb_xgmii_tx_mac import xgmii_tx_pkg::*; ();

    localparam int NUM_ROWS = 9;
    localparam int MIN_BYTES = 60;
    localparam int IPG_MIN = 12;
    localparam logic [31:0] START_WORD = {MAC_PRE, MAC_PRE, MAC_PRE, RS_START};

    // Frame length in bytes and idle cycles before the frame is offered
    int frame_len [NUM_ROWS] = '{64, 65, 66, 67, 1, 17, 59, 60, 61};
    int idle_before [NUM_ROWS] = '{2, 0, 0, 0, 3, 0, 0, 0, 5};

    logic i_clk;
    logic i_reset;
    lane_data_t i_tdata;
    lane_ctl_t i_tkeep;
    logic i_tlast;
    logic i_tvalid;
    logic o_tready;
    lane_data_t o_xgmii_data;
    lane_ctl_t o_xgmii_ctl;

    logic [7:0] payload [NUM_ROWS][128];
    logic [7:0] exp_byte [$];
    logic exp_ctl [$];
    int seed;
    int errors;
    int checks;
    int err_base;
    int tests_failed;
    int cycle_cnt;
    int cycle_limit;
    // Monitor position in the output stream
    logic in_frame;
    int mon_row;
    int mon_pos;
    int gap_bytes;

    `include "tb_frame_model.svh"

    xgmii_tx_mac #(
        .MIN_FRAME_BYTES(MIN_BYTES),
        .IPG_BYTES(IPG_MIN)
    ) uut (
        .i_clk(i_clk),
        .i_reset(i_reset),
        .i_tdata(i_tdata),
        .i_tkeep(i_tkeep),
        .i_tlast(i_tlast),
        .i_tvalid(i_tvalid),
        .o_tready(o_tready),
        .o_xgmii_data(o_xgmii_data),
        .o_xgmii_ctl(o_xgmii_ctl)
    );

    initial begin
        i_clk = 1'b0;
        forever #5 i_clk = ~i_clk;
    end

    task automatic report_test(input string name);
        if (errors > err_base) begin
            tests_failed++;
            $display("Test %s: FAIL (%0d errors)", name, errors - err_base);
        end else begin
            $display("Test %s: PASS", name);
        end
        err_base = errors;
    endtask

    // Follows one output byte through idle gaps and frames
    task automatic track_byte(input logic [7:0] b, input logic c, input int lane);
        int exp_gap;
        if (in_frame) begin
            check_value($sformatf("o_xgmii_data row %0d byte %0d", mon_row, mon_pos),
                        exp_byte[mon_pos], b);
            check_value($sformatf("o_xgmii_ctl row %0d byte %0d", mon_row, mon_pos),
                        exp_ctl[mon_pos], c);
            mon_pos++;
            if (mon_pos == exp_byte.size()) begin
                in_frame = 1'b0;
                gap_bytes = 0;
                report_test($sformatf("row %0d, %0d byte frame", mon_row, frame_len[mon_row]));
                mon_row++;
            end
        end else if (c && b == RS_IDLE) begin
            gap_bytes++;
        end else if (c && b == RS_START && mon_row < NUM_ROWS) begin
            check_value("o_xgmii_ctl start lane", 0, lane);
            if (mon_row > 0) begin
                // Back-to-back frames allow up to three extra idle bytes
                exp_gap = (gap_bytes < IPG_MIN) ? IPG_MIN : gap_bytes;
                if (idle_before[mon_row] == 0 && gap_bytes > IPG_MIN + 3) begin
                    exp_gap = IPG_MIN + 3;
                end
                check_value($sformatf("o_xgmii idle bytes before row %0d", mon_row),
                            exp_gap, gap_bytes);
            end
            build_expected(mon_row);
            in_frame = 1'b1;
            mon_pos = 1;
        end else begin
            errors++;
            $display("ERROR at %0t: unexpected byte 0x%02h with control %0b outside a frame",
                     $time, b, c);
        end
    endtask

    always @(posedge i_clk) begin
        if (!i_reset) begin
            for (int l = 0; l < DATA_NBYTES; l++) begin
                track_byte(o_xgmii_data[8*l +: 8], o_xgmii_ctl[l], l);
            end
        end
    end

    always @(posedge i_clk) begin
        cycle_cnt++;
        if (cycle_cnt >= cycle_limit) begin
            $display("ERROR: run did not finish within %0d cycles", cycle_limit);
            $display("Regression failed");
            $finish;
        end
    end

    // Offers one frame, holding each beat until it is accepted
    task automatic send_frame(input int row);
        int nbeats;
        int b;
        int idx;
        logic ready;
        logic first_seen;
        nbeats = (frame_len[row] + 3) / 4;
        b = 0;
        first_seen = 1'b0;
        if (idle_before[row] > 0) begin
            i_tvalid = 1'b0;
            i_tlast = 1'b0;
            repeat (idle_before[row]) @(negedge i_clk);
        end
        while (b < nbeats) begin
            for (int l = 0; l < DATA_NBYTES; l++) begin
                idx = 4 * b + l;
                i_tkeep[l] = (idx < frame_len[row]);
                i_tdata[8*l +: 8] = (idx < frame_len[row]) ? payload[row][idx] : 8'hEE;
            end
            i_tlast = (b == nbeats - 1);
            i_tvalid = 1'b1;
            #1;
            ready = o_tready;
            // Ready returns only in idle, where the first start column goes out
            if (ready && !first_seen) begin
                first_seen = 1'b1;
                check_value("o_xgmii_ctl at first beat", 4'b0001, o_xgmii_ctl);
                check_value("o_xgmii_data at first beat", START_WORD, o_xgmii_data);
            end
            @(negedge i_clk);
            if (ready) begin
                b++;
            end
        end
        check_value("o_tready after last beat", 0, o_tready);
    endtask

    initial begin
        seed = 56;
        errors = 0;
        checks = 0;
        err_base = 0;
        tests_failed = 0;
        cycle_cnt = 0;
        in_frame = 1'b0;
        mon_row = 0;
        mon_pos = 0;
        gap_bytes = 0;
        i_reset = 1'b1;
        i_tdata = '0;
        i_tkeep = '0;
        i_tlast = 1'b0;
        i_tvalid = 1'b0;
        cycle_limit = 100;
        for (int r = 0; r < NUM_ROWS; r++) begin
            cycle_limit += frame_len[r] / 4 + 24 + idle_before[r];
            for (int i = 0; i < frame_len[r]; i++) begin
                payload[r][i] = 8'($random(seed));
            end
        end

        repeat (2) @(negedge i_clk);
        i_reset = 1'b0;

        // Link comes up idle with the input open
        while (!o_tready) begin
            @(negedge i_clk);
        end
        repeat (4) begin
            check_value("o_xgmii_ctl after reset", 4'hF, o_xgmii_ctl);
            check_value("o_xgmii_data after reset", {4{RS_IDLE}}, o_xgmii_data);
            check_value("o_tready after reset", 1, o_tready);
            @(negedge i_clk);
        end
        report_test("idle after reset");

        for (int r = 0; r < NUM_ROWS; r++) begin
            send_frame(r);
        end
        i_tvalid = 1'b0;
        i_tlast = 1'b0;
        while (mon_row < NUM_ROWS || !o_tready) begin
            @(negedge i_clk);
        end
        repeat (4) @(negedge i_clk);

        $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 NUM_ROWS + 1, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: xgmii_tx_mac.f
+incdir+verification
design/xgmii_tx_pkg.sv
design/crc32_slice.sv
design/tx_term_builder.sv
design/tx_frame_ctrl.sv
design/xgmii_tx_mac.sv
verification/tb_xgmii_tx_mac.sv
